//--- all.f
conv_pkg.sv
conv_mem.sv
conv_csr.sv
conv_fsm.sv
conv_counter.sv
conv_datapath.sv
conv_top.sv
tb_conv_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_top
LINT_TOP  ?= conv_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;
    import conv_pkg::*;

    typedef struct packed {
        logic [15:0] height;
        logic [15:0] width;
        logic [5:0]  ifm_off;
        logic [5:0]  wt_off;
        logic [5:0]  ofm_off;
        logic [5:0]  fill_bits; // random bits per filled word.
    } case_t;

    typedef enum int {
        RUN_PLAIN,
        RUN_DOUBLE_START,
        RUN_ABORT
    } run_mode_e;

    logic          clk = 1'b0;
    logic          reset_i;
    conv_bus_req_t req;
    conv_word_t    rdata_o;
    logic          active_o;

    conv_word_t    shadow [CONV_MEM_DEPTH];
    logic [15:0]   lfsr_q = 16'd24;
    logic          active_q = 1'b0;
    int            run_count = 0;

    conv_status_t  status_idle = '{zero: '0, idle: 1'b1, done: 1'b0};
    conv_status_t  status_done = '{zero: '0, idle: 1'b1, done: 1'b1};

    // height, width, input, weight and output offsets, fill bits.
    case_t case_tbl [5] = '{
        '{16'd5, 16'd5, 6'd0,  6'd25, 6'd34, 6'd8},
        '{16'd4, 16'd6, 6'd0,  6'd30, 6'd40, 6'd32},
        '{16'd3, 16'd3, 6'd10, 6'd0,  6'd20, 6'd16},
        '{16'd6, 16'd4, 6'd8,  6'd40, 6'd50, 6'd32},
        '{16'd3, 16'd8, 6'd0,  6'd24, 6'd33, 6'd4}
    };

    conv_top i_conv_top (
        .clk(clk), .reset_i(reset_i), .req_i(req), .rdata_o(rdata_o), .active_o(active_o)
    );

    always #10 clk = ~clk;

    // every rising edge of active_o is one run of the engine.
    always @(posedge clk) begin
        active_q <= active_o;
        if (active_o && !active_q) begin
            run_count <= run_count + 1;
        end
    end

    // -------- helpers --------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11 + 1.
    endfunction

    function automatic conv_word_t next_rand(input int nbits);
        conv_word_t v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input conv_word_t got, input conv_word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_status(input conv_status_t got, input conv_status_t exp,
                                input string what);
        if (got !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s got idle %b done %b, expected idle %b done %b",
                               $time, what, got.idle, got.done, exp.idle, exp.done));
        end
    endtask

    task automatic bus_write(input logic [CONV_ADDR_W-1:0] addr, input logic [3:0] we,
                             input conv_word_t data);
        @(negedge clk);
        req.we    = we;
        req.re    = 1'b0;
        req.addr  = addr;
        req.wdata = data;
        @(negedge clk);
        req = '0;
    endtask

    task automatic bus_read(input logic [CONV_ADDR_W-1:0] addr, output conv_word_t data);
        @(negedge clk);
        req.re   = 1'b1;
        req.addr = addr;
        @(negedge clk);
        data = rdata_o; // read data is registered, so it is stable here.
        req  = '0;
    endtask

    task automatic mem_write(input int idx, input conv_word_t v);
        bus_write(CONV_MEM_BASE + CONV_ADDR_W'(idx), 4'hf, v);
        shadow[idx] = v;
    endtask

    task automatic mem_read(input int idx, output conv_word_t v);
        bus_read(CONV_MEM_BASE + CONV_ADDR_W'(idx), v);
    endtask

    task automatic wait_status(input conv_status_t exp, input string what);
        conv_word_t w;
        int         polls;
        polls = 0;
        bus_read(CONV_STATUS, w);
        while (conv_status_t'(w) !== exp) begin
            polls++;
            if (polls > 2000) begin
                fail_run($sformatf("timed out polling the status word while waiting for %s",
                                   what));
            end
            bus_read(CONV_STATUS, w);
        end
    endtask

    // -------- one convolution --------
    task automatic run_case(input case_t c, input run_mode_e mode);
        int         h;
        int         w;
        int         runs_before;
        int         exp_runs;
        conv_word_t acc;
        conv_word_t got;
        h = int'(c.height);
        w = int'(c.width);
        exp_runs = (mode == RUN_ABORT) ? 2 : 1;
        bus_write(CONV_FM_DIM, 4'hf, {c.height, c.width});
        bus_write(CONV_INPUT_FM, 4'hf, {26'd0, c.ifm_off});
        bus_write(CONV_WEIGHT_OFF, 4'hf, {26'd0, c.wt_off});
        bus_write(CONV_OUTPUT_FM, 4'hf, {26'd0, c.ofm_off});
        for (int i = 0; i < h * w; i++) begin
            mem_write(int'(c.ifm_off) + i, next_rand(int'(c.fill_bits)));
        end
        for (int t = 0; t < 9; t++) begin
            mem_write(int'(c.wt_off) + t, next_rand(int'(c.fill_bits)));
        end
        runs_before = run_count;
        bus_write(CONV_START, 4'h1, 32'hffff_ffff);
        if (mode == RUN_DOUBLE_START) begin
            repeat (12) @(negedge clk);
            bus_write(CONV_START, 4'hf, '0); // engine is busy here.
        end
        if (mode == RUN_ABORT) begin
            repeat (15) @(negedge clk);
            bus_write(CONV_RESET, 4'h8, '0);
            wait_status(status_idle, "idle after abort");
            bus_read(CONV_FM_DIM, got);
            check_word(got, {c.height, c.width}, "dimensions after abort");
            bus_read(CONV_INPUT_FM, got);
            check_word(got, {26'd0, c.ifm_off}, "input offset after abort");
            bus_read(CONV_WEIGHT_OFF, got);
            check_word(got, {26'd0, c.wt_off}, "weight offset after abort");
            bus_read(CONV_OUTPUT_FM, got);
            check_word(got, {26'd0, c.ofm_off}, "output offset after abort");
            bus_write(CONV_START, 4'h2, '0);
        end
        wait_status(status_done, "done");
        repeat (20) @(negedge clk);
        bus_read(CONV_STATUS, got);
        check_status(conv_status_t'(got), status_done, "status after the run");
        if (run_count != runs_before + exp_runs) begin
            fail_run($sformatf("ERROR at %0t: the engine started %0d times, expected %0d",
                               $time, run_count - runs_before, exp_runs));
        end

        // reference model over every valid output pixel.
        for (int r = 0; r < h - 2; r++) begin
            for (int col = 0; col < w - 2; col++) begin
                acc = '0;
                for (int t = 0; t < 9; t++) begin
                    acc = acc + shadow[int'(c.wt_off) + t] *
                          shadow[int'(c.ifm_off) + (r + t / 3) * w + col + t % 3];
                end
                mem_read(int'(c.ofm_off) + r * (w - 2) + col, got);
                check_word(got, acc, $sformatf("output pixel (%0d,%0d)", r, col));
            end
        end
        for (int i = 0; i < h * w; i++) begin
            mem_read(int'(c.ifm_off) + i, got);
            check_word(got, shadow[int'(c.ifm_off) + i], "input word after the run");
        end
        for (int t = 0; t < 9; t++) begin
            mem_read(int'(c.wt_off) + t, got);
            check_word(got, shadow[int'(c.wt_off) + t], "weight word after the run");
        end
    endtask

    // -------- sequence --------
    initial begin
        conv_word_t w;
        req     = '0;
        reset_i = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        bus_read(CONV_STATUS, w);
        check_status(conv_status_t'(w), status_idle, "status after reset");
        for (int a = 3; a <= 6; a++) begin
            bus_read(CONV_ADDR_W'(a), w);
            check_word(w, '0, $sformatf("register %0d after reset", a));
        end
        bus_read(8'h20, w);
        check_word(w, '0, "unmapped read");

        // byte lanes
        bus_write(CONV_WEIGHT_OFF, 4'hf, 32'h1122_3344);
        bus_write(CONV_WEIGHT_OFF, 4'b0101, 32'haabb_ccdd);
        bus_read(CONV_WEIGHT_OFF, w);
        check_word(w, 32'h11bb_33dd, "partial register write");
        bus_write(CONV_FM_DIM, 4'hf, 32'h0005_0005);
        bus_write(CONV_FM_DIM, 4'b0011, 32'h1234_0007);
        bus_read(CONV_FM_DIM, w);
        check_word(w, 32'h0005_0007, "partial dimension write");
        mem_write(5, 32'h0102_0304);
        bus_write(CONV_MEM_BASE + 8'd5, 4'b1010, 32'hf0e0_d0c0);
        mem_read(5, w);
        check_word(w, 32'hf002_d004, "partial memory write");

        for (int i = 0; i < $size(case_tbl); i++) begin
            run_case(case_tbl[i], RUN_PLAIN);
        end
        run_case(case_tbl[0], RUN_DOUBLE_START);
        run_case(case_tbl[1], RUN_ABORT);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  conv_pkg::conv_bus_req_t req_i,
    output conv_pkg::conv_word_t    rdata_o,
    output logic                    active_o
);
    import conv_pkg::*;

    conv_cfg_t              cfg;
    logic                   start;
    logic                   abort;
    logic                   mem_sel;
    logic [CONV_ADDR_W-1:0] mem_off;
    conv_word_t             host_rdata;
    logic                   fsm_idle;
    logic                   done_pulse;
    conv_state_e            state;
    logic                   cnt_en;
    logic                   cnt_clr;
    conv_pos_t              pos;
    logic [CONV_MEM_AW-1:0] eng_rd_addr;
    conv_word_t             eng_rd_data;
    logic                   eng_we;
    logic [CONV_MEM_AW-1:0] eng_wr_addr;
    conv_word_t             eng_wr_data;
    logic                   rd_last;

    assign mem_off  = req_i.addr - CONV_MEM_BASE;
    assign active_o = ~fsm_idle;

    // host side --------------------
    conv_csr i_csr (
        .clk(clk), .reset_i(reset_i), .req_i(req_i), .rdata_o(rdata_o),
        .mem_rdata_i(host_rdata), .fsm_idle_i(fsm_idle), .done_pulse_i(done_pulse),
        .cfg_o(cfg), .start_o(start), .abort_o(abort), .mem_sel_o(mem_sel)
    );

    conv_mem i_mem (
        .clk(clk), .host_we_i(req_i.we & {4{mem_sel}}),
        .host_addr_i(mem_off[CONV_MEM_AW-1:0]), .host_wdata_i(req_i.wdata),
        .host_rdata_o(host_rdata), .eng_rd_addr_i(eng_rd_addr), .eng_rd_data_o(eng_rd_data),
        .eng_we_i(eng_we), .eng_wr_addr_i(eng_wr_addr), .eng_wr_data_i(eng_wr_data)
    );

    // engine --------------------
    conv_fsm i_fsm (
        .clk(clk), .reset_i(reset_i), .start_i(start), .abort_i(abort), .pos_i(pos),
        .rd_last_i(rd_last), .state_o(state), .cnt_en_o(cnt_en), .cnt_clr_o(cnt_clr),
        .idle_o(fsm_idle), .done_o(done_pulse)
    );

    conv_counter i_counter (
        .clk(clk), .reset_i(reset_i), .en_i(cnt_en), .clr_i(cnt_clr),
        .dim_i(cfg.fm_dim.dim), .pos_o(pos)
    );

    conv_datapath i_datapath (
        .clk(clk), .reset_i(reset_i), .state_i(state), .pos_i(pos), .cfg_i(cfg),
        .rd_addr_o(eng_rd_addr), .rd_data_i(eng_rd_data), .wr_en_o(eng_we),
        .wr_addr_o(eng_wr_addr), .wr_data_o(eng_wr_data), .rd_last_o(rd_last)
    );

endmodule

`default_nettype wire

//--- conv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module conv_datapath (
    input  logic                                clk,
    input  logic                                reset_i,
    input  conv_pkg::conv_state_e               state_i,
    input  conv_pkg::conv_pos_t                 pos_i,
    input  conv_pkg::conv_cfg_t                 cfg_i,
    output logic [conv_pkg::CONV_MEM_AW-1:0]    rd_addr_o,
    input  conv_pkg::conv_word_t                rd_data_i,
    output logic                                wr_en_o,
    output logic [conv_pkg::CONV_MEM_AW-1:0]    wr_addr_o,
    output conv_pkg::conv_word_t                wr_data_o,
    output logic                                rd_last_o
);
    import conv_pkg::*;

    conv_word_t             wt_q [9];
    conv_word_t             width;
    conv_word_t             wt_addr;
    conv_word_t             ifm_addr;
    conv_word_t             rd_word;
    conv_word_t             ofm_addr;
    conv_word_t             prod;
    conv_word_t             acc_sum;
    conv_word_t             acc_q;
    logic [1:0]             k_row;
    logic [3:0]             k_col;
    logic                   ld_vld_q;
    logic                   run_vld_q;
    logic                   last_tap_q;
    logic                   last_pix_q;
    logic [3:0]             tap_q;
    logic [5:0]             row_q;
    logic [5:0]             col_q;
    logic                   wr_en_q;
    logic                   wr_last_q;
    logic [CONV_MEM_AW-1:0] wr_addr_q;
    conv_word_t             wr_data_q;

    // read address --------------------
    assign width = {16'd0, cfg_i.fm_dim.dim.width};
    assign k_row = (pos_i.tap >= 4'd6) ? 2'd2 : (pos_i.tap >= 4'd3) ? 2'd1 : 2'd0;
    assign k_col = pos_i.tap - {1'b0, k_row, 1'b0} - {2'b0, k_row}; // tap mod 3.

    assign wt_addr  = cfg_i.wt_off + {28'd0, pos_i.tap};
    assign ifm_addr = cfg_i.ifm_off + ({26'd0, pos_i.row} + {30'd0, k_row}) * width +
                      {26'd0, pos_i.col} + {28'd0, k_col};
    assign rd_word   = (state_i == S_LOAD_WT) ? wt_addr : ifm_addr;
    assign rd_addr_o = rd_word[CONV_MEM_AW-1:0];

    // multiply-accumulate, one cycle behind the read --------------------
    assign prod     = wt_q[tap_q] * rd_data_i; // wraps at 32 bits.
    assign acc_sum  = ((tap_q == 4'd0) ? '0 : acc_q) + prod;
    assign ofm_addr = cfg_i.ofm_off + {26'd0, row_q} * (width - 32'd2) + {26'd0, col_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ld_vld_q  <= 1'b0;
            run_vld_q <= 1'b0;
            wr_en_q   <= 1'b0;
        end else begin
            ld_vld_q  <= (state_i == S_LOAD_WT);
            run_vld_q <= (state_i == S_RUN);
            // after an abort the state is idle and reads still in flight are dropped.
            wr_en_q   <= run_vld_q && last_tap_q && (state_i != S_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        tap_q      <= pos_i.tap;
        row_q      <= pos_i.row;
        col_q      <= pos_i.col;
        last_tap_q <= pos_i.last_tap;
        last_pix_q <= pos_i.last_pixel;
        if (ld_vld_q) begin
            wt_q[tap_q] <= rd_data_i;
        end
        if (run_vld_q) begin
            acc_q <= acc_sum;
        end
        wr_addr_q <= ofm_addr[CONV_MEM_AW-1:0];
        wr_data_q <= acc_sum;
        wr_last_q <= last_pix_q;
    end

    assign wr_en_o   = wr_en_q && (state_i != S_IDLE); // a write still in the pipe is dropped.
    assign wr_addr_o = wr_addr_q;
    assign wr_data_o = wr_data_q;
    assign rd_last_o = wr_en_q && wr_last_q; // final pixel is on its way to memory.

endmodule

`default_nettype wire

//--- conv_counter.sv
`timescale 1ns/1ps
`default_nettype none

module conv_counter (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                en_i,
    input  logic                clr_i,
    input  conv_pkg::conv_dim_t dim_i,
    output conv_pkg::conv_pos_t pos_o
);
    import conv_pkg::*;

    logic [5:0]  row_q;
    logic [5:0]  col_q;
    logic [3:0]  tap_q;
    logic [15:0] col_max;
    logic [15:0] row_max;
    logic        last_tap;
    logic        last_col;
    logic        last_row;

    // only valid output pixels are walked, so both limits are size minus three.
    assign col_max  = dim_i.width - 16'd3;
    assign row_max  = dim_i.height - 16'd3;
    assign last_tap = (tap_q == 4'd8);
    assign last_col = ({10'd0, col_q} == col_max);
    assign last_row = ({10'd0, row_q} == row_max);

    always_ff @(posedge clk) begin
        if (reset_i || clr_i) begin
            row_q <= '0;
            col_q <= '0;
            tap_q <= '0;
        end else if (en_i) begin
            if (!last_tap) begin
                tap_q <= tap_q + 4'd1;
            end else begin
                tap_q <= '0;
                if (!last_col) begin
                    col_q <= col_q + 6'd1;
                end else begin
                    col_q <= '0;
                    row_q <= last_row ? 6'd0 : row_q + 6'd1;
                end
            end
        end
    end

    assign pos_o = '{row: row_q, col: col_q, tap: tap_q,
                     last_tap: last_tap, last_pixel: last_col && last_row};

endmodule

`default_nettype wire

//--- conv_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module conv_fsm (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  logic                  abort_i,
    input  conv_pkg::conv_pos_t   pos_i,
    input  logic                  rd_last_i,
    output conv_pkg::conv_state_e state_o,
    output logic                  cnt_en_o,
    output logic                  cnt_clr_o,
    output logic                  idle_o,
    output logic                  done_o
);
    import conv_pkg::*;

    conv_state_e state_q;
    conv_state_e state_d;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        cnt_en_o  = 1'b0;
        cnt_clr_o = 1'b0;
        done_o    = 1'b0;
        case (state_q)
            S_IDLE: begin
                cnt_clr_o = 1'b1; // hold the counter at zero.
                if (start_i) begin
                    state_d = S_LOAD_WT;
                end
            end
            S_LOAD_WT: begin
                cnt_en_o = 1'b1;
                if (pos_i.last_tap) begin
                    cnt_clr_o = 1'b1; // the run starts again from tap 0 of pixel 0.
                    state_d   = S_RUN;
                end
            end
            S_RUN: begin
                cnt_en_o = 1'b1;
                if (pos_i.last_tap && pos_i.last_pixel) begin
                    cnt_clr_o = 1'b1;
                    state_d   = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (rd_last_i) begin
                    state_d = S_DONE;
                end
            end
            S_DONE: begin
                done_o  = 1'b1;
                state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
        if (abort_i) begin
            state_d   = S_IDLE;
            cnt_clr_o = 1'b1;
        end
    end

    assign state_o = state_q;
    assign idle_o  = (state_q == S_IDLE);

endmodule

`default_nettype wire

//--- conv_csr.sv
`timescale 1ns/1ps
`default_nettype none

module conv_csr (
    input  logic                   clk,
    input  logic                   reset_i,
    input  conv_pkg::conv_bus_req_t req_i,
    output conv_pkg::conv_word_t   rdata_o,
    input  conv_pkg::conv_word_t   mem_rdata_i,
    input  logic                   fsm_idle_i,
    input  logic                   done_pulse_i,
    output conv_pkg::conv_cfg_t    cfg_o,
    output logic                   start_o,
    output logic                   abort_o,
    output logic                   mem_sel_o
);
    import conv_pkg::*;

    logic         wr_any;
    conv_cfg_t    cfg_q;
    logic         idle_q;
    logic         done_q;
    conv_status_t status;
    conv_word_t   reg_rdata;
    conv_word_t   rd_q;
    logic         hit_q;

    assign wr_any    = |req_i.we;
    assign start_o   = wr_any && (req_i.addr == CONV_START);
    assign abort_o   = wr_any && (req_i.addr == CONV_RESET);
    assign mem_sel_o = (req_i.addr >= CONV_MEM_BASE) &&
                       (req_i.addr < CONV_MEM_BASE + CONV_ADDR_W'(CONV_MEM_DEPTH));
    assign cfg_o     = cfg_q;

    // configuration registers --------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q <= '0;
        end else if (wr_any) begin
            case (req_i.addr)
                CONV_FM_DIM:     cfg_q.fm_dim.raw <= conv_merge_bytes(cfg_q.fm_dim.raw,
                                                                      req_i.wdata, req_i.we);
                CONV_INPUT_FM:   cfg_q.ifm_off <= conv_merge_bytes(cfg_q.ifm_off,
                                                                   req_i.wdata, req_i.we);
                CONV_WEIGHT_OFF: cfg_q.wt_off <= conv_merge_bytes(cfg_q.wt_off,
                                                                  req_i.wdata, req_i.we);
                CONV_OUTPUT_FM:  cfg_q.ofm_off <= conv_merge_bytes(cfg_q.ofm_off,
                                                                   req_i.wdata, req_i.we);
                default: ;
            endcase
        end
    end

    // status --------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            idle_q <= 1'b1;
            done_q <= 1'b0;
        end else begin
            idle_q <= fsm_idle_i;
            if (abort_o || (start_o && fsm_idle_i)) begin
                done_q <= 1'b0; // a new run or an abort clears the sticky flag.
            end else if (done_pulse_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign status = '{zero: '0, idle: idle_q, done: done_q};

    always_comb begin
        case (req_i.addr)
            CONV_STATUS:     reg_rdata = status;
            CONV_FM_DIM:     reg_rdata = cfg_q.fm_dim.raw;
            CONV_INPUT_FM:   reg_rdata = cfg_q.ifm_off;
            CONV_WEIGHT_OFF: reg_rdata = cfg_q.wt_off;
            CONV_OUTPUT_FM:  reg_rdata = cfg_q.ofm_off;
            default:         reg_rdata = '0;
        endcase
    end

    // memory data shows up one cycle after the read and is then captured so it holds.
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_q  <= '0;
            hit_q <= 1'b0;
        end else if (req_i.re) begin
            rd_q  <= reg_rdata;
            hit_q <= mem_sel_o;
        end else if (hit_q) begin
            rd_q  <= mem_rdata_i;
            hit_q <= 1'b0;
        end
    end

    assign rdata_o = hit_q ? mem_rdata_i : rd_q;

endmodule

`default_nettype wire

//--- conv_mem.sv
`timescale 1ns/1ps
`default_nettype none

module conv_mem (
    input  logic                             clk,
    input  logic [3:0]                       host_we_i,
    input  logic [conv_pkg::CONV_MEM_AW-1:0] host_addr_i,
    input  conv_pkg::conv_word_t             host_wdata_i,
    output conv_pkg::conv_word_t             host_rdata_o,
    input  logic [conv_pkg::CONV_MEM_AW-1:0] eng_rd_addr_i,
    output conv_pkg::conv_word_t             eng_rd_data_o,
    input  logic                             eng_we_i,
    input  logic [conv_pkg::CONV_MEM_AW-1:0] eng_wr_addr_i,
    input  conv_pkg::conv_word_t             eng_wr_data_i
);
    import conv_pkg::*;

    conv_word_t mem_q [CONV_MEM_DEPTH];
    logic       host_blocked;

    // the engine wins when both ports write the same word.
    assign host_blocked = eng_we_i && (eng_wr_addr_i == host_addr_i);

    always_ff @(posedge clk) begin
        if (eng_we_i) begin
            mem_q[eng_wr_addr_i] <= eng_wr_data_i;
        end
        if ((|host_we_i) && !host_blocked) begin
            mem_q[host_addr_i] <= conv_merge_bytes(mem_q[host_addr_i], host_wdata_i, host_we_i);
        end
        host_rdata_o  <= mem_q[host_addr_i];
        eng_rd_data_o <= mem_q[eng_rd_addr_i];
    end

endmodule

`default_nettype wire

//--- conv_pkg.sv
`default_nettype none

package conv_pkg;

    // address map, in bus words --------------------
    localparam int CONV_ADDR_W    = 8;
    localparam int CONV_MEM_DEPTH = 64;
    localparam int CONV_MEM_AW    = $clog2(CONV_MEM_DEPTH);

    localparam logic [CONV_ADDR_W-1:0] CONV_MEM_BASE   = 8'h40;
    localparam logic [CONV_ADDR_W-1:0] CONV_RESET      = 8'd0;
    localparam logic [CONV_ADDR_W-1:0] CONV_START      = 8'd1;
    localparam logic [CONV_ADDR_W-1:0] CONV_STATUS     = 8'd2;
    localparam logic [CONV_ADDR_W-1:0] CONV_FM_DIM     = 8'd3;
    localparam logic [CONV_ADDR_W-1:0] CONV_INPUT_FM   = 8'd4;
    localparam logic [CONV_ADDR_W-1:0] CONV_WEIGHT_OFF = 8'd5;
    localparam logic [CONV_ADDR_W-1:0] CONV_OUTPUT_FM  = 8'd6;

    // types --------------------
    typedef logic [31:0] conv_word_t;

    typedef struct packed {
        logic [15:0] height;
        logic [15:0] width;
    } conv_dim_t;

    // the dimension register is written as one word and read back in halves.
    typedef union packed {
        conv_word_t raw;
        conv_dim_t  dim;
    } conv_cfg_u;

    typedef struct packed {
        logic [3:0]             we;
        logic                   re;
        logic [CONV_ADDR_W-1:0] addr;
        conv_word_t             wdata;
    } conv_bus_req_t;

    typedef struct packed {
        conv_cfg_u  fm_dim;
        conv_word_t ifm_off;
        conv_word_t wt_off;
        conv_word_t ofm_off;
    } conv_cfg_t;

    typedef struct packed {
        logic [29:0] zero;
        logic        idle;
        logic        done;
    } conv_status_t;

    typedef struct packed {
        logic [5:0] row;
        logic [5:0] col;
        logic [3:0] tap;
        logic       last_tap;
        logic       last_pixel;
    } conv_pos_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_WT,
        S_RUN,
        S_DRAIN,
        S_DONE
    } conv_state_e;

    // replaces only the bytes whose enable is set.
    function automatic conv_word_t conv_merge_bytes(conv_word_t old_w, conv_word_t new_w,
                                                    logic [3:0] be);
        conv_word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire
